//--- common/io_pkg.sv
/*
 * user-facing output types
 * front panel byte, key events and joystick words
 */
`include "user_io_defs.svh"

package io_pkg;

	// buttons/switches byte, bit 0 is the lowest field
	typedef struct packed {
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} panel_t;

	// one decoded key
	typedef struct packed {
		logic                   pressed;
		logic                   extended;
		logic [`UIO_BYTE_W-1:0] code;
	} key_event_t;

	// joystick word, byte 1 of the payload lands in bits 7:0
	typedef logic [`UIO_JOY_BYTES*`UIO_BYTE_W-1:0] joy_word_t;

endpackage

//--- common/spi_cmd_pkg.sv
/*
 * SPI command package
 * command codes sent by the IO controller and the received-byte type
 */
`include "user_io_defs.svh"

package spi_cmd_pkg;

	// command byte values handled by the decoder
	typedef enum logic [7:0] {
		CMD_BUT_SW   = 8'h01,
		CMD_KBD      = 8'h05,
		CMD_STATUS8  = 8'h15,
		CMD_STATUS64 = 8'h1e,
		CMD_CORE_MOD = 8'h21,
		CMD_JOY0     = 8'h60,
		CMD_JOY1     = 8'h61
	} cmd_e;

	// byte as handed over from the SPI_CLK domain
	// toggle inverts once per completed byte
	typedef struct packed {
		logic [`UIO_BYTE_W-1:0] data;
		logic                   toggle;
	} spi_byte_t;

	// keyboard prefix bytes
	localparam logic [7:0] KEY_EXT_PREFIX   = 8'he0;
	localparam logic [7:0] KEY_BREAK_PREFIX = 8'hf0;

endpackage

//--- common/user_io_defs.svh
/*
 * user I/O constants
 * byte width, PS/2 timing, keyboard FIFO depth and joystick layout
 */
`ifndef USER_IO_DEFS_SVH
`define USER_IO_DEFS_SVH

// one SPI byte
`define UIO_BYTE_W 8

// clk_sys cycles between PS/2 clock toggles
// kept short so frames stay small in simulation
`define UIO_PS2_DIV 4

// log2 of keyboard FIFO depth
`define UIO_PS2_FIFO_BITS 4

// digital joysticks and their word size
`define UIO_JOY_COUNT 2
`define UIO_JOY_BYTES 4

// 64-bit status word
`define UIO_STATUS_BYTES 8

`endif

//--- files.f
+incdir+common
common/spi_cmd_pkg.sv
common/io_pkg.sv
spi/spi_byte_rx.sv
logic/cmd_decoder.sv
ps2/ps2_fifo.sv
ps2/ps2_tx.sv
logic/user_io_top.sv
verif/tb_user_io.sv

//--- logic/cmd_decoder.sv
/*
 * command decoder
 * brings SPI bytes into clk_sys, parses the command transfers, updates
 * the core registers and turns keyboard payloads into key events
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module cmd_decoder (
	input  logic                                      clk_sys,
	input  logic                                      SPI_SS_IO,
	input  spi_cmd_pkg::spi_byte_t                    rx_i,
	input  logic                                      active_i,
	input  logic                                      kbd_ready_i,
	input  logic                                      kbd_ack_i,
	output logic                                      kbd_req_o,
	output logic [`UIO_BYTE_W-1:0]                    kbd_byte_o,
	output io_pkg::panel_t                            panel_o,
	output io_pkg::joy_word_t                         joy0_o,
	output io_pkg::joy_word_t                         joy1_o,
	output logic [`UIO_STATUS_BYTES*`UIO_BYTE_W-1:0]  status_o,
	output logic [6:0]                                core_mod_o,
	output io_pkg::key_event_t                        key_o,
	output logic                                      key_strobe_o
);

	localparam int STATUS_W = `UIO_STATUS_BYTES * `UIO_BYTE_W;

	// toggle: [0] first flop, [1] synced, [2] previous
	logic [2:0]             tog_sync_q;
	logic [1:0]             act_sync_q;
	logic                   rx_fire;
	logic [`UIO_BYTE_W-1:0] rx_byte;
	logic                   is_prefix;
	logic [3:0]             byte_cnt_q;
	logic [3:0]             pay_idx;
	logic [7:0]             cmd_q;
	logic                   kbd_ok_q;
	logic                   ext_q;
	logic                   brk_q;
	logic                   kbd_req_q;
	logic                   key_strobe_q;

	logic [`UIO_BYTE_W-1:0] kbd_byte_q;
	io_pkg::joy_word_t      joy_q [`UIO_JOY_COUNT];
	io_pkg::panel_t         panel_q;
	logic [STATUS_W-1:0]    status_q;
	logic [6:0]             core_mod_q;
	io_pkg::key_event_t     key_q;

	assign rx_byte   = rx_i.data;
	assign rx_fire   = act_sync_q[1] & (tog_sync_q[2] ^ tog_sync_q[1]);
	assign pay_idx   = byte_cnt_q - 4'd1;
	assign is_prefix = (rx_byte == spi_cmd_pkg::KEY_EXT_PREFIX) ||
		(rx_byte == spi_cmd_pkg::KEY_BREAK_PREFIX);

	// transfer state, cleared by chip select
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tog_sync_q   <= '0;
			act_sync_q   <= '0;
			byte_cnt_q   <= '0;
			cmd_q        <= '0;
			kbd_ok_q     <= 1'b0;
			ext_q        <= 1'b0;
			brk_q        <= 1'b0;
			kbd_req_q    <= 1'b0;
			key_strobe_q <= 1'b0;
		end else begin
			tog_sync_q   <= {tog_sync_q[1:0], rx_i.toggle};
			act_sync_q   <= {act_sync_q[0], active_i};
			key_strobe_q <= 1'b0;

			// second half of the four-phase write
			if (kbd_req_q && kbd_ack_i) begin
				kbd_req_q <= 1'b0;
			end

			if (!act_sync_q[1]) begin
				byte_cnt_q <= '0;
				kbd_ok_q   <= 1'b0;
				ext_q      <= 1'b0;
				brk_q      <= 1'b0;
			end else if (rx_fire) begin
				if (byte_cnt_q != 4'hf) begin
					byte_cnt_q <= byte_cnt_q + 4'd1;
				end
				if (byte_cnt_q == 4'd0) begin
					cmd_q    <= rx_byte;
					// forward only if the whole packet is sure to fit
					kbd_ok_q <= (rx_byte == spi_cmd_pkg::CMD_KBD) && kbd_ready_i;
				end else if (cmd_q == spi_cmd_pkg::CMD_KBD) begin
					if (kbd_ok_q) begin
						kbd_req_q <= 1'b1;
					end
					if (rx_byte == spi_cmd_pkg::KEY_EXT_PREFIX) begin
						ext_q <= 1'b1;
					end else if (rx_byte == spi_cmd_pkg::KEY_BREAK_PREFIX) begin
						brk_q <= 1'b1;
					end else begin
						key_strobe_q <= 1'b1;
					end
				end
			end
		end
	end

	// core registers keep their value across transfers
	always_ff @(posedge clk_sys) begin
		if (rx_fire && byte_cnt_q != 4'd0) begin
			case (cmd_q)
				spi_cmd_pkg::CMD_BUT_SW: panel_q <= io_pkg::panel_t'(rx_byte[6:0]);
				spi_cmd_pkg::CMD_JOY0, spi_cmd_pkg::CMD_JOY1: begin
					if (byte_cnt_q <= `UIO_JOY_BYTES) begin
						joy_q[cmd_q[0]][pay_idx[1:0]*`UIO_BYTE_W +: `UIO_BYTE_W] <= rx_byte;
					end
				end
				// 8-bit status also clears the upper bytes
				spi_cmd_pkg::CMD_STATUS8: status_q <= STATUS_W'(rx_byte);
				spi_cmd_pkg::CMD_STATUS64: begin
					if (byte_cnt_q <= `UIO_STATUS_BYTES) begin
						status_q[pay_idx[2:0]*`UIO_BYTE_W +: `UIO_BYTE_W] <= rx_byte;
					end
				end
				// variant comes from the first payload byte only
				spi_cmd_pkg::CMD_CORE_MOD: begin
					if (byte_cnt_q == 4'd1) begin
						core_mod_q <= rx_byte[6:0];
					end
				end
				spi_cmd_pkg::CMD_KBD: begin
					kbd_byte_q <= rx_byte;
					if (!is_prefix) begin
						key_q <= '{pressed: !brk_q, extended: ext_q, code: rx_byte};
					end
				end
				default: ;
			endcase
		end
	end

	assign kbd_req_o    = kbd_req_q;
	assign kbd_byte_o   = kbd_byte_q;
	assign panel_o      = panel_q;
	assign joy0_o       = joy_q[0];
	assign joy1_o       = joy_q[1];
	assign status_o     = status_q;
	assign core_mod_o   = core_mod_q;
	assign key_o        = key_q;
	assign key_strobe_o = key_strobe_q;

endmodule

//--- logic/user_io_top.sv
/*
 * user I/O top level
 * SPI receiver, command decoder and PS/2 keyboard path
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module user_io_top (
	input  logic                                      clk_sys,
	input  logic                                      SPI_SS_IO,
	input  logic                                      SPI_CLK,
	input  logic                                      SPI_MOSI,
	output io_pkg::panel_t                            panel_o,
	output io_pkg::joy_word_t                         joy0_o,
	output io_pkg::joy_word_t                         joy1_o,
	output logic [`UIO_STATUS_BYTES*`UIO_BYTE_W-1:0]  status_o,
	output logic [6:0]                                core_mod_o,
	output io_pkg::key_event_t                        key_o,
	output logic                                      key_strobe_o,
	output logic                                      ps2_kbd_clk_o,
	output logic                                      ps2_kbd_data_o
);

	spi_cmd_pkg::spi_byte_t rx;
	logic                   rx_active;
	logic                   kbd_ready;
	logic                   kbd_req;
	logic                   kbd_ack;
	logic [`UIO_BYTE_W-1:0] kbd_byte;
	logic                   tx_req;
	logic                   tx_ack;
	logic [`UIO_BYTE_W-1:0] tx_byte;
	logic                   ps2_flush;

	// status bit 0 is the core reset from the IO controller
	assign ps2_flush = status_o[0];

	spi_byte_rx u_spi_byte_rx (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_MOSI  (SPI_MOSI),
		.rx_o      (rx),
		.active_o  (rx_active)
	);

	cmd_decoder u_cmd_decoder (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.rx_i         (rx),
		.active_i     (rx_active),
		.kbd_ready_i  (kbd_ready),
		.kbd_ack_i    (kbd_ack),
		.kbd_req_o    (kbd_req),
		.kbd_byte_o   (kbd_byte),
		.panel_o      (panel_o),
		.joy0_o       (joy0_o),
		.joy1_o       (joy1_o),
		.status_o     (status_o),
		.core_mod_o   (core_mod_o),
		.key_o        (key_o),
		.key_strobe_o (key_strobe_o)
	);

	ps2_fifo u_ps2_fifo (
		.clk_sys   (clk_sys),
		.flush_i   (ps2_flush),
		.wr_req_i  (kbd_req),
		.wr_byte_i (kbd_byte),
		.wr_ack_o  (kbd_ack),
		.ready_o   (kbd_ready),
		.tx_req_o  (tx_req),
		.tx_byte_o (tx_byte),
		.tx_ack_i  (tx_ack)
	);

	ps2_tx u_ps2_tx (
		.clk_sys        (clk_sys),
		.flush_i        (ps2_flush),
		.tx_req_i       (tx_req),
		.tx_byte_i      (tx_byte),
		.tx_ack_o       (tx_ack),
		.ps2_kbd_clk_o  (ps2_kbd_clk_o),
		.ps2_kbd_data_o (ps2_kbd_data_o)
	);

endmodule

//--- ps2/ps2_fifo.sv
/*
 * PS/2 keyboard byte FIFO
 * circular buffer between the decoder and the PS/2 transmitter,
 * four-phase req/ack on both sides
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module ps2_fifo (
	input  logic                   clk_sys,
	input  logic                   flush_i,
	input  logic                   wr_req_i,
	input  logic [`UIO_BYTE_W-1:0] wr_byte_i,
	output logic                   wr_ack_o,
	output logic                   ready_o,
	output logic                   tx_req_o,
	output logic [`UIO_BYTE_W-1:0] tx_byte_o,
	input  logic                   tx_ack_i
);

	localparam int AW    = `UIO_PS2_FIFO_BITS;
	localparam int DEPTH = 1 << AW;

	logic [`UIO_BYTE_W-1:0] mem_q [DEPTH];
	logic [AW-1:0]          wptr_q;
	logic [AW-1:0]          rptr_q;
	logic [AW:0]            used_q;
	logic [AW:0]            free;
	logic                   wr_ack_q;
	logic                   rd_seen_q;
	logic                   push;
	logic                   pop;

	assign free = (AW+1)'(DEPTH) - used_q;
	// write on the req edge, pop on the ack edge
	assign push = wr_req_i && !wr_ack_q && !flush_i && (free != '0);
	assign pop  = tx_ack_i && !rd_seen_q && !flush_i;

	always_ff @(posedge clk_sys) begin
		if (flush_i) begin
			wptr_q    <= '0;
			rptr_q    <= '0;
			used_q    <= '0;
			wr_ack_q  <= 1'b0;
			rd_seen_q <= 1'b0;
		end else begin
			wr_ack_q  <= wr_req_i;
			rd_seen_q <= tx_ack_i;
			wptr_q    <= wptr_q + AW'(push);
			rptr_q    <= rptr_q + AW'(pop);
			used_q    <= used_q + (AW+1)'(push) - (AW+1)'(pop);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem_q[wptr_q] <= wr_byte_i;
		end
	end

	assign wr_ack_o  = wr_ack_q;
	// room for a full keyboard packet
	assign ready_o   = free >= (AW+1)'(4);
	// req drops while the current ack is still up
	assign tx_req_o  = (used_q != '0) && !rd_seen_q;
	assign tx_byte_o = mem_q[rptr_q];

endmodule

//--- ps2/ps2_tx.sv
/*
 * PS/2 keyboard transmitter
 * divides clk_sys into the PS/2 clock and sends one frame per byte
 * with start, eight data bits LSB first, odd parity and stop
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module ps2_tx (
	input  logic                   clk_sys,
	input  logic                   flush_i,
	input  logic                   tx_req_i,
	input  logic [`UIO_BYTE_W-1:0] tx_byte_i,
	output logic                   tx_ack_o,
	output logic                   ps2_kbd_clk_o,
	output logic                   ps2_kbd_data_o
);

	localparam int DIV_W = $clog2(`UIO_PS2_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UIO_PS2_DIV);

	localparam logic [3:0] ST_IDLE   = 4'd0;
	localparam logic [3:0] ST_PARITY = 4'd9;
	localparam logic [3:0] ST_STOP   = 4'd10;
	localparam logic [3:0] ST_DONE   = 4'd11;

	logic [DIV_W-1:0]       div_q;
	logic                   ps2_clk_q;
	logic                   ps2_rise;
	logic [3:0]             state_q;
	logic [`UIO_BYTE_W-1:0] shift_q;
	logic                   parity_q;
	logic                   data_q;
	logic                   ack_q;

	// the internal clock goes high on this cycle's edge
	assign ps2_rise = (div_q == DIV_LAST) && !ps2_clk_q;

	always_ff @(posedge clk_sys) begin
		if (flush_i) begin
			div_q     <= '0;
			ps2_clk_q <= 1'b0;
			state_q   <= ST_IDLE;
			data_q    <= 1'b1;
			ack_q     <= 1'b0;
		end else begin
			if (div_q == DIV_LAST) begin
				div_q     <= '0;
				ps2_clk_q <= ~ps2_clk_q;
			end else begin
				div_q <= div_q + 1'b1;
			end

			if (!tx_req_i) begin
				ack_q <= 1'b0;
			end

			// data changes on the rising edge, host samples on falling
			if (ps2_rise) begin
				case (state_q)
					ST_IDLE: begin
						data_q <= 1'b1;
						if (tx_req_i && !ack_q) begin
							shift_q  <= tx_byte_i;
							parity_q <= 1'b1;
							ack_q    <= 1'b1;
							data_q   <= 1'b0;
							state_q  <= 4'd1;
						end
					end
					ST_PARITY: begin
						data_q  <= parity_q;
						state_q <= ST_STOP;
					end
					ST_STOP: begin
						data_q  <= 1'b1;
						state_q <= ST_DONE;
					end
					ST_DONE: state_q <= ST_IDLE;
					default: begin
						data_q   <= shift_q[0];
						shift_q  <= shift_q >> 1;
						parity_q <= parity_q ^ shift_q[0];
						state_q  <= state_q + 4'd1;
					end
				endcase
			end
		end
	end

	assign tx_ack_o       = ack_q;
	// clock only runs while a frame is going out
	assign ps2_kbd_clk_o  = ps2_clk_q || (state_q == ST_IDLE);
	assign ps2_kbd_data_o = data_q;

endmodule

//--- spi/spi_byte_rx.sv
/*
 * SPI byte receiver
 * assembles MOSI bits into bytes on SPI_CLK and flags each one by
 * inverting a toggle for the clk_sys side
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module spi_byte_rx (
	input  logic                   SPI_CLK,
	input  logic                   SPI_SS_IO,
	input  logic                   SPI_MOSI,
	output spi_cmd_pkg::spi_byte_t rx_o,
	output logic                   active_o
);

	localparam int BIT_W = $clog2(`UIO_BYTE_W);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UIO_BYTE_W - 1);

	logic [BIT_W-1:0]        bit_cnt_q;
	logic [`UIO_BYTE_W-2:0]  sbuf_q;
	logic [`UIO_BYTE_W-1:0]  byte_q;
	logic                    tog_q;
	logic                    act_q;

	// counters and strobe, held clear while chip select is high
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt_q <= '0;
			tog_q     <= 1'b0;
			act_q     <= 1'b0;
		end else begin
			act_q     <= 1'b1;
			bit_cnt_q <= bit_cnt_q + 1'b1;
			// byte complete, flip the toggle for the other domain
			if (bit_cnt_q == LAST_BIT) begin
				tog_q <= ~tog_q;
			end
		end
	end

	// data path, MSB arrives first
	always_ff @(posedge SPI_CLK) begin
		sbuf_q <= {sbuf_q[`UIO_BYTE_W-3:0], SPI_MOSI};
		if (bit_cnt_q == LAST_BIT) begin
			byte_q <= {sbuf_q, SPI_MOSI};
		end
	end

	// byte stays stable until the next one completes
	assign rx_o     = '{data: byte_q, toggle: tog_q};
	assign active_o = act_q;

endmodule

//--- verif/tb_user_io.sv
/*
 * testbench for the user I/O block
 * replays SPI transfers from the golden file and checks the registers,
 * the key events and every PS/2 frame that leaves the keyboard path
 */
`timescale 1ns/10ps
`include "user_io_defs.svh"

module tb_user_io;

	localparam int MAX_T = 32;
	localparam int MAX_B = 12;
	localparam int MAX_E = 8;

	logic                                     clk_sys;
	logic                                     SPI_SS_IO;
	logic                                     SPI_CLK;
	logic                                     SPI_MOSI;
	io_pkg::panel_t                           panel;
	io_pkg::joy_word_t                        joy0;
	io_pkg::joy_word_t                        joy1;
	logic [`UIO_STATUS_BYTES*`UIO_BYTE_W-1:0] status;
	logic [6:0]                               core_mod;
	io_pkg::key_event_t                       key;
	logic                                     key_strobe;
	logic                                     ps2_clk;
	logic                                     ps2_data;

	// transfers as read from the golden file
	logic [7:0]  kind_mem [MAX_T];
	logic [7:0]  cmd_mem [MAX_T];
	int          len_mem [MAX_T];
	int          cnt_mem [MAX_T];
	logic [7:0]  pay_mem [MAX_T][MAX_B];
	logic [63:0] exp_mem [MAX_T][MAX_E];
	int          n_lines;

	logic [9:0] key_got [$];
	logic [7:0] ps2_exp [$];
	logic       ps2_armed;
	int         cycle_cnt;
	int         cycle_limit;

	user_io_top u_user_io_top (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.SPI_CLK        (SPI_CLK),
		.SPI_MOSI       (SPI_MOSI),
		.panel_o        (panel),
		.joy0_o         (joy0),
		.joy1_o         (joy1),
		.status_o       (status),
		.core_mod_o     (core_mod),
		.key_o          (key),
		.key_strobe_o   (key_strobe),
		.ps2_kbd_clk_o  (ps2_clk),
		.ps2_kbd_data_o (ps2_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("timeout after %0d clk_sys cycles, the DUT stopped making progress",
				cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// key events, sampled half a cycle after they change
	always @(negedge clk_sys) begin
		if (key_strobe === 1'b1) begin
			key_got.push_back(key);
		end
	end

	// PS/2 frame monitor, samples data where the host would
	initial begin : ps2_monitor
		logic [10:0] bits;
		int i;
		wait (ps2_armed);
		forever begin
			for (i = 0; i < 11; i++) begin
				@(negedge ps2_clk);
				bits[i] = ps2_data;
			end
			check_value(bits[0], 1'b0, "ps2 start bit");
			check_value(^bits[9:1], 1'b1, "ps2 odd parity");
			check_value(bits[10], 1'b1, "ps2 stop bit");
			if (ps2_exp.size() == 0) begin
				$display("PS/2 frame carrying %h was sent but no byte was expected", bits[8:1]);
				$display("RESULT: FAIL");
				$fatal(1, "unexpected frame");
			end else begin
				check_value(bits[8:1], ps2_exp.pop_front(), "ps2 byte");
			end
		end
	end

	task automatic load_golden();
		int fd;
		int r;
		int i;
		bit ok;
		logic [63:0] tok;
		logic [8*128-1:0] rest;
		ok = 1'b1;
		n_lines = 0;
		// reset and the final idle check
		cycle_limit = 200;
		fd = $fopen("verif/user_io_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/user_io_golden.txt, there is no stimulus to run");
			$display("RESULT: FAIL");
			$fatal(1, "missing golden file");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					r = $fgets(rest, fd);
				end else begin
					kind_mem[n_lines] = tok[7:0];
					r = $fscanf(fd, "%h %d", cmd_mem[n_lines], len_mem[n_lines]);
					ok &= (r == 2);
					for (i = 0; i < len_mem[n_lines]; i++) begin
						r = $fscanf(fd, "%h", pay_mem[n_lines][i]);
						ok &= (r == 1);
					end
					r = $fscanf(fd, "%d", cnt_mem[n_lines]);
					ok &= (r == 1);
					for (i = 0; i < cnt_mem[n_lines]; i++) begin
						r = $fscanf(fd, "%h", exp_mem[n_lines][i]);
						ok &= (r == 1);
					end
					cycle_limit += 200 * (len_mem[n_lines] + 1);
					if (tok[7:0] == "K") begin
						cycle_limit += 150 * len_mem[n_lines];
					end
					n_lines++;
				end
			end
			$fclose(fd);
			if (!ok || n_lines == 0) begin
				$display("golden file is malformed or holds no transfers");
				$display("RESULT: FAIL");
				$fatal(1, "bad golden file");
			end
		end
	endtask

	// step to 1 ns after the n-th rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	// MSB first, 8 clk_sys cycles per SPI_CLK half period
	task automatic send_byte(input logic [7:0] v);
		int k;
		for (k = 7; k >= 0; k--) begin
			SPI_MOSI = v[k];
			wait_cycles(8);
			SPI_CLK = 1'b1;
			wait_cycles(8);
			SPI_CLK = 1'b0;
		end
	endtask

	task automatic spi_transfer(input int t);
		int i;
		wait_cycles(1);
		SPI_SS_IO = 1'b0;
		send_byte(cmd_mem[t]);
		for (i = 0; i < len_mem[t]; i++) begin
			send_byte(pay_mem[t][i]);
		end
		// last byte must reach the decoder before chip select clears it
		wait_cycles(8);
		SPI_SS_IO = 1'b1;
	endtask

	task automatic check_result(input int t);
		logic [63:0] e;
		int i;
		e = exp_mem[t][0];
		if (kind_mem[t] == "K") begin
			check_value(key_got.size(), cnt_mem[t], "key strobe count");
			for (i = 0; i < cnt_mem[t]; i++) begin
				check_value(key_got[i], exp_mem[t][i], "key event");
			end
		end else begin
			check_value(key_got.size(), 0, "key strobe outside a keyboard transfer");
			case (cmd_mem[t])
				8'h01: begin
					check_value(panel.buttons, e[1:0], "panel buttons");
					check_value(panel.switches, e[3:2], "panel switches");
					check_value(panel.scandoubler_disable, e[4], "scandoubler_disable");
					check_value(panel.ypbpr, e[5], "ypbpr");
					check_value(panel.no_csync, e[6], "no_csync");
				end
				8'h21: check_value(core_mod, e, "core_mod");
				8'h60: check_value(joy0, e, "joy0");
				8'h61: check_value(joy1, e, "joy1");
				default: check_value(status, e, "status");
			endcase
		end
		if (kind_mem[t] == "C") begin
			// PS/2 lines held idle while the core sits in reset
			check_value(ps2_clk, 1'b1, "ps2 clock during core reset");
			check_value(ps2_data, 1'b1, "ps2 data during core reset");
		end
		key_got.delete();
	endtask

	initial begin
		int t;
		int i;
		int rng_seed;
		SPI_SS_IO = 1'b1;
		SPI_CLK   = 1'b0;
		SPI_MOSI  = 1'b0;
		ps2_armed = 1'b0;
		rng_seed  = $urandom(49994);
		load_golden();
		// chip select high doubles as the reset
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(key_strobe, 1'b0, "key strobe after reset");
		for (t = 0; t < n_lines; t++) begin
			if (kind_mem[t] == "K") begin
				for (i = 0; i < len_mem[t]; i++) begin
					ps2_exp.push_back(pay_mem[t][i]);
				end
			end
			spi_transfer(t);
			@(negedge clk_sys);
			check_result(t);
			if (kind_mem[t] == "C") begin
				ps2_armed = 1'b1;
			end
			wait_cycles(4 + int'($urandom % 16));
		end
		// drain the queued frames, then the lines must rest high
		while (ps2_exp.size() != 0) begin
			@(posedge clk_sys);
		end
		repeat (150) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(ps2_clk, 1'b1, "ps2 clock idle at end");
		check_value(ps2_data, 1'b1, "ps2 data idle at end");
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- verif/user_io_golden.txt
# kind cmd len payload... count expected...   (C core reset, R register, K keyboard)
# R/C expect one register value; K expects key events as {pressed, extended, code}
C 1e 8 01 de ad be ef 12 34 56 1 563412efbeadde01
R 1e 8 10 32 54 76 98 ba dc fe 1 fedcba9876543210
R 01 1 b5 1 35
R 21 1 c3 1 43
R 15 1 5a 1 5a
R 60 4 11 22 33 44 1 44332211
R 61 6 a1 b2 c3 d4 e5 f6 1 d4c3b2a1
K 05 1 1c 1 21c
K 05 2 e0 75 1 375
K 05 3 e0 f0 75 1 175
K 05 2 f0 1c 1 01c
K 05 4 1c 32 e0 74 3 21c 232 374
K 05 3 e0 f0 74 1 174
R 01 1 4a 1 4a
R 61 4 0f 00 00 80 1 8000000f
R 21 2 7e 11 1 7e
